// File: nibble_cpu.f
+incdir+src
src/nibble_isa_pkg.sv
src/nibble_path_pkg.sv
src/control_unit.sv
src/result_select.sv
src/reg_state.sv
src/nibble_cpu.sv
bench/nibble_cpu_checker.sv
bench/nibble_cpu_properties.sv
bench/nibble_cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator, then scan the log for the fail message
verilator --binary --timing --assert --top-module nibble_cpu_tb \
   -f nibble_cpu.f -o nibble_cpu_sim \
   && ./obj_dir/nibble_cpu_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0

// File: bench/nibble_cpu_tb.sv
`timescale 1ns/1ps
`include "nibble_cpu_defs.svh"

module nibble_cpu_tb;

   localparam int NUM_ENTRIES = 9;
   localparam int CYCLE_LIMIT = NUM_ENTRIES * 68 + 100;

   // Sequencer cycles per instruction class, fetch and decode included
   localparam int LOAD_CYC  = 5;
   localparam int SHORT_CYC = 3;
   localparam int MEM_CYC   = 4;
   localparam int SWAP_CYC  = 5;

   logic                      clk = 1'b0;
   logic                      nRst = 1'b0;
   nibble_path_pkg::mem_req_t mem_req;
   logic [`NC_WORD_W-1:0]     mem_rdata;
   logic [`NC_WORD_W-1:0]     mem [256];
   logic [`NC_WORD_W-1:0]     image [256];
   logic                      arm = 1'b0;
   logic [`NC_WORD_W-1:0]     exp_addr = '0;
   logic [`NC_WORD_W-1:0]     exp_data = '0;
   int                        exp_cyc = 0;
   logic                      done;
   int                        err_count;
   int                        cycles = 0;
   logic [31:0]               rng = 32'h2c227b10;

   // Stimulus and expected values per entry
   logic [`NC_WORD_W-1:0]     tbl_regs [NUM_ENTRIES][4];
   logic [31:0]               tbl_prog [NUM_ENTRIES];
   logic [`NC_WORD_W-1:0]     tbl_addr [NUM_ENTRIES];
   logic [`NC_WORD_W-1:0]     tbl_data [NUM_ENTRIES];
   int                        tbl_cyc  [NUM_ENTRIES];

   always #2 clk = ~clk;

   nibble_cpu dut_i (
      .clk       (clk),
      .nRst      (nRst),
      .mem_req   (mem_req),
      .mem_rdata (mem_rdata)
   );

   nibble_cpu_checker check_i (
      .clk       (clk),
      .arm       (arm),
      .mem_req   (mem_req),
      .exp_addr  (exp_addr),
      .exp_data  (exp_data),
      .exp_cyc   (exp_cyc),
      .done      (done),
      .err_count (err_count)
   );

   // Memory model reloads the image while reset is low
   assign mem_rdata = mem[mem_req.addr];

   always @(posedge clk) begin
      if (!nRst) begin
         for (int a = 0; a < 256; a++) begin
            mem[a] <= image[a];
         end
      end else if (mem_req.we) begin
         mem[mem_req.addr] <= mem_req.wdata;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TB FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [7:0] next_byte();
      rng = xorshift(rng);
      return rng[7:0];
   endfunction

   function automatic logic [7:0] fill_byte(input logic [7:0] a);
      return (a * 8'd37) ^ 8'h6b;
   endfunction

   function automatic logic [7:0] alu_expect(input nibble_isa_pkg::opcode_e op,
                                             input logic [7:0] a, input logic [7:0] b);
      case (op)
         nibble_isa_pkg::IR_ADD: return a + b;
         nibble_isa_pkg::IR_SUB: return a - b;
         nibble_isa_pkg::IR_MUL: return a * b;
         default:                return ~(a & b);
      endcase
   endfunction

   task automatic set_entry(input int e, input logic [7:0] r0, input logic [7:0] r1,
                            input logic [7:0] r2, input logic [7:0] r3,
                            input logic [31:0] prog, input logic [7:0] addr,
                            input logic [7:0] data, input int cyc);
      tbl_regs[e] = '{r0, r1, r2, r3};
      tbl_prog[e] = prog;
      tbl_addr[e] = addr;
      tbl_data[e] = data;
      tbl_cyc[e]  = cyc;
   endtask

   task automatic build_table();
      nibble_isa_pkg::opcode_e ops [4];
      logic [7:0] r [4];
      ops = '{nibble_isa_pkg::IR_ADD, nibble_isa_pkg::IR_SUB,
              nibble_isa_pkg::IR_MUL, nibble_isa_pkg::IR_NAND};
      // op, SW01, SW12, STW
      for (int e = 0; e < 4; e++) begin
         for (int k = 0; k < 4; k++) begin
            r[k] = next_byte();
         end
         set_entry(e, r[0], r[1], r[2], r[3], {4'(ops[e]), 28'h45DFFFF},
                   r[3], alu_expect(ops[e], r[1], r[2]),
                   LOAD_CYC + SHORT_CYC + 2 * SWAP_CYC + MEM_CYC);
      end
      for (int k = 0; k < 4; k++) begin
         r[k] = next_byte();
      end
      // SW23 then STW writes old r3 to old r2
      set_entry(4, r[0], r[1], r[2], r[3], 32'h6DFFFFFF, r[2], r[3],
                LOAD_CYC + SWAP_CYC + MEM_CYC);
      // LDW then STW from byte 0x40
      set_entry(5, r[0], r[1], fill_byte(8'h40) ^ 8'h01, 8'h40, 32'hCDFFFFFF,
                8'h40, fill_byte(8'h40), LOAD_CYC + 2 * MEM_CYC);
      // BE to nibble 12 skips SW12 and the first STW
      set_entry(6, r[0], 8'h5c, 8'h5c, 8'd12, 32'h75DFDFFF, 8'd12, 8'h5c,
                LOAD_CYC + SHORT_CYC + MEM_CYC);
      set_entry(7, r[0], 8'h21, 8'h93, 8'd12, 32'h75DFDFFF, 8'd12, 8'h21,
                LOAD_CYC + SHORT_CYC + SWAP_CYC + MEM_CYC);
      // ADD, no-op, REF, SW01, SW12, STW
      set_entry(8, (r[1] + r[2]) ^ 8'h80, r[1], r[2], r[3], 32'h0FE45DFF,
                r[3], (r[1] + r[2]) ^ 8'h80,
                LOAD_CYC + 2 * SHORT_CYC + 2 * MEM_CYC + 2 * SWAP_CYC);
   endtask

   task automatic load_image(input int e);
      for (int a = 0; a < 256; a++) begin
         image[a] = fill_byte(8'(a));
      end
      for (int i = 0; i < 4; i++) begin
         image[i]     = tbl_regs[e][i];
         image[4 + i] = tbl_prog[e][31 - 8*i -: 8];
      end
   endtask

   initial begin
      build_table();
      for (int e = 0; e < NUM_ENTRIES; e++) begin
         @(posedge clk);
         nRst <= 1'b0;
         arm  <= 1'b0;
         load_image(e);
         repeat (8) @(posedge clk);
         exp_addr <= tbl_addr[e];
         exp_data <= tbl_data[e];
         exp_cyc  <= tbl_cyc[e];
         arm      <= 1'b1;
         nRst     <= 1'b1;
         while (done !== 1'b1) @(posedge clk);
         arm <= 1'b0;
      end
      @(posedge clk);
      $display("Entries run: %0d, errors: %0d", NUM_ENTRIES, err_count);
      if (err_count == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: bench/nibble_cpu_properties.sv
`timescale 1ns/1ps
`include "nibble_cpu_defs.svh"

module nibble_cpu_properties (
   input logic                       clk,
   input logic                       nRst,
   input nibble_path_pkg::ctrl_t     ctrl,
   input nibble_isa_pkg::opcode_e    ir,
   input logic [`NC_WORD_W-1:0]      pc,
   input nibble_isa_pkg::seq_state_e state,
   input nibble_path_pkg::mem_req_t  mem_req
);

   we_not_with_ale: assert property (@(posedge clk) disable iff (!nRst)
      !(ctrl.mem_we && ctrl.ale))
      else $error("memory write enable high while address latches");

   ir_stable: assert property (@(posedge clk) disable iff (!nRst)
      (state != nibble_isa_pkg::DECODE) |=> $stable(ir))
      else $error("ir changed outside DECODE");

   pc_stable: assert property (@(posedge clk) disable iff (!nRst)
      (state != nibble_isa_pkg::DECODE && state != nibble_isa_pkg::EXEC_1) |=> $stable(pc))
      else $error("pc changed outside DECODE and EXEC_1");

   bus_known: assert property (@(posedge clk) disable iff (!nRst)
      !$isunknown(mem_req))
      else $error("memory bus has unknown bits");

endmodule

bind nibble_cpu nibble_cpu_properties props_i (
   .clk     (clk),
   .nRst    (nRst),
   .ctrl    (ctrl),
   .ir      (ir),
   .pc      (pc),
   .state   (ctrl_i.state),
   .mem_req (mem_req)
);

// File: bench/nibble_cpu_checker.sv
`timescale 1ns/1ps
`include "nibble_cpu_defs.svh"

module nibble_cpu_checker (
   input  logic                      clk,
   input  logic                      arm,
   input  nibble_path_pkg::mem_req_t mem_req,
   input  logic [`NC_WORD_W-1:0]     exp_addr,
   input  logic [`NC_WORD_W-1:0]     exp_data,
   input  int                        exp_cyc,
   output logic                      done,
   output int                        err_count
);

   localparam int STORE_WAIT = 60;

   logic done_r = 1'b0;
   int   errors = 0;
   int   wait_cnt = 0;

   assign done      = done_r;
   assign err_count = errors;

   // First bus write after reset release is the one compared
   always @(posedge clk) begin
      int n;
      n = 0;
      if (!arm) begin
         done_r   <= 1'b0;
         wait_cnt <= 0;
      end else if (!done_r) begin
         if (mem_req.we) begin
            if (mem_req.addr !== exp_addr) begin
               $display("[ERROR] %0t mem_req.addr: got %h, expected %h",
                        $time, mem_req.addr, exp_addr);
               n++;
            end
            if (mem_req.wdata !== exp_data) begin
               $display("[ERROR] %0t mem_req.wdata: got %h, expected %h",
                        $time, mem_req.wdata, exp_data);
               n++;
            end
            // Cycle count since reset release, this cycle included
            if (wait_cnt + 1 != exp_cyc) begin
               $display("[ERROR] %0t store cycle: got %0d, expected %0d",
                        $time, wait_cnt + 1, exp_cyc);
               n++;
            end
            done_r <= 1'b1;
         end else if (wait_cnt == STORE_WAIT) begin
            $display("No store came within %0d cycles of reset release", STORE_WAIT);
            n++;
            done_r <= 1'b1;
         end else begin
            wait_cnt <= wait_cnt + 1;
         end
      end
      errors <= errors + n;
   end

endmodule

// File: src/nibble_cpu.sv
`timescale 1ns/1ps
`include "nibble_cpu_defs.svh"

module nibble_cpu (
   input  logic                      clk,
   input  logic                      nRst,
   output nibble_path_pkg::mem_req_t mem_req,
   input  logic [`NC_WORD_W-1:0]     mem_rdata
);

   nibble_path_pkg::ctrl_t  ctrl;
   nibble_isa_pkg::opcode_e ir;
   logic                    equal;
   logic [`NC_WORD_W-1:0]   result;
   logic [`NC_WORD_W-1:0]   pc;
   logic [`NC_WORD_W-1:0]   r0;
   logic [`NC_WORD_W-1:0]   r1;
   logic [`NC_WORD_W-1:0]   r2;
   logic [`NC_WORD_W-1:0]   r3;

   control_unit ctrl_i (
      .clk   (clk),
      .nRst  (nRst),
      .ir    (ir),
      .equal (equal),
      .ctrl  (ctrl)
   );

   result_select sel_i (
      .sel    (ctrl.sel),
      .pc     (pc),
      .r0     (r0),
      .r1     (r1),
      .r2     (r2),
      .r3     (r3),
      .rdata  (mem_rdata),
      .result (result),
      .equal  (equal)
   );

   reg_state regs_i (
      .clk     (clk),
      .nRst    (nRst),
      .ctrl    (ctrl),
      .result  (result),
      .rdata   (mem_rdata),
      .mem_req (mem_req),
      .pc      (pc),
      .r0      (r0),
      .r1      (r1),
      .r2      (r2),
      .r3      (r3),
      .ir      (ir)
   );

endmodule

// File: src/reg_state.sv
`timescale 1ns/1ps
`include "nibble_cpu_defs.svh"

module reg_state (
   input  logic                      clk,
   input  logic                      nRst,
   input  nibble_path_pkg::ctrl_t    ctrl,
   input  logic [`NC_WORD_W-1:0]     result,
   input  logic [`NC_WORD_W-1:0]     rdata,
   output nibble_path_pkg::mem_req_t mem_req,
   output logic [`NC_WORD_W-1:0]     pc,
   output logic [`NC_WORD_W-1:0]     r0,
   output logic [`NC_WORD_W-1:0]     r1,
   output logic [`NC_WORD_W-1:0]     r2,
   output logic [`NC_WORD_W-1:0]     r3,
   output nibble_isa_pkg::opcode_e   ir
);

   logic [`NC_WORD_W-1:0] regs [`NC_NUM_REGS];
   logic [`NC_WORD_W-1:0] addr;
   logic [`NC_INSN_W-1:0] nibble;

   // High nibble executes first
   assign nibble = pc[0] ? rdata[`NC_INSN_W-1:0] : rdata[2*`NC_INSN_W-1:`NC_INSN_W];

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc   <= `NC_WORD_W'(`NC_RESET_PC);
         ir   <= nibble_isa_pkg::IR_ADD;
         addr <= '0;
         for (int i = 0; i < `NC_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (ctrl.pc_we) begin
            pc <= result;
         end
         if (ctrl.ir_we) begin
            ir <= nibble_isa_pkg::opcode_e'(nibble);
         end
         if (ctrl.reg_we) begin
            regs[ctrl.reg_tgt[1:0]] <= ctrl.reg_tgt[2] ? result : rdata;
         end
         if (ctrl.ale) begin
            addr <= result;
         end
      end
   end

   assign r0 = regs[0];
   assign r1 = regs[1];
   assign r2 = regs[2];
   assign r3 = regs[3];

   // Read data follows addr combinationally in the memory
   assign mem_req.addr  = addr;
   assign mem_req.wdata = result;
   assign mem_req.we    = ctrl.mem_we;

endmodule

// File: src/result_select.sv
`timescale 1ns/1ps
`include "nibble_cpu_defs.svh"

module result_select (
   input  nibble_path_pkg::result_sel_e sel,
   input  logic [`NC_WORD_W-1:0]        pc,
   input  logic [`NC_WORD_W-1:0]        r0,
   input  logic [`NC_WORD_W-1:0]        r1,
   input  logic [`NC_WORD_W-1:0]        r2,
   input  logic [`NC_WORD_W-1:0]        r3,
   input  logic [`NC_WORD_W-1:0]        rdata,
   output logic [`NC_WORD_W-1:0]        result,
   output logic                         equal
);

   // Branch condition for BE
   assign equal = (r1 == r2);

   always_comb begin
      case (sel)
         nibble_path_pkg::SEL_ADD:     result = r1 + r2;
         nibble_path_pkg::SEL_SUB:     result = r1 - r2;
         // Low byte of the product only
         nibble_path_pkg::SEL_MUL:     result = r1 * r2;
         nibble_path_pkg::SEL_NAND:    result = ~(r1 & r2);
         nibble_path_pkg::SEL_XOR01:   result = r0 ^ r1;
         nibble_path_pkg::SEL_XOR12:   result = r1 ^ r2;
         nibble_path_pkg::SEL_XOR23:   result = r2 ^ r3;
         nibble_path_pkg::SEL_C0:      result = `NC_WORD_W'(0);
         nibble_path_pkg::SEL_C1:      result = `NC_WORD_W'(1);
         nibble_path_pkg::SEL_C2:      result = `NC_WORD_W'(2);
         nibble_path_pkg::SEL_C3:      result = `NC_WORD_W'(3);
         // Nibble address to byte address
         nibble_path_pkg::SEL_PC_HALF: result = {1'b0, pc[`NC_WORD_W-1:1]};
         nibble_path_pkg::SEL_PC_INC:  result = pc + 1'b1;
         nibble_path_pkg::SEL_R3:      result = r3;
         nibble_path_pkg::SEL_R2:      result = r2;
         nibble_path_pkg::SEL_RDATA:   result = rdata;
         default:                      result = '0;
      endcase
   end

endmodule

// File: src/control_unit.sv
`timescale 1ns/1ps

module control_unit (
   input  logic                    clk,
   input  logic                    nRst,
   input  nibble_isa_pkg::opcode_e ir,
   input  logic                    equal,
   output nibble_path_pkg::ctrl_t  ctrl
);

   nibble_isa_pkg::seq_state_e state;
   nibble_isa_pkg::seq_state_e state_nxt;

   always_comb begin
      state_nxt = nibble_isa_pkg::FETCH;
      case (state)
         nibble_isa_pkg::LOAD_0: state_nxt = nibble_isa_pkg::LOAD_1;
         nibble_isa_pkg::LOAD_1: state_nxt = nibble_isa_pkg::LOAD_2;
         nibble_isa_pkg::LOAD_2: state_nxt = nibble_isa_pkg::LOAD_3;
         nibble_isa_pkg::LOAD_3: state_nxt = nibble_isa_pkg::LOAD_4;
         nibble_isa_pkg::FETCH:  state_nxt = nibble_isa_pkg::DECODE;
         nibble_isa_pkg::DECODE: state_nxt = nibble_isa_pkg::EXEC_1;
         nibble_isa_pkg::EXEC_1: begin
            if (ir inside {nibble_isa_pkg::IR_SW01, nibble_isa_pkg::IR_SW12,
                           nibble_isa_pkg::IR_SW23, nibble_isa_pkg::IR_LDW,
                           nibble_isa_pkg::IR_STW, nibble_isa_pkg::IR_REF})
               state_nxt = nibble_isa_pkg::EXEC_2;
         end
         nibble_isa_pkg::EXEC_2: begin
            // Only swaps need a third step
            if (ir inside {nibble_isa_pkg::IR_SW01, nibble_isa_pkg::IR_SW12,
                           nibble_isa_pkg::IR_SW23})
               state_nxt = nibble_isa_pkg::EXEC_3;
         end
         default: state_nxt = nibble_isa_pkg::FETCH;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= nibble_isa_pkg::LOAD_0;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      ctrl         = '0;
      ctrl.sel     = nibble_path_pkg::SEL_C0;
      ctrl.reg_tgt = 3'b100;
      case (state)
         nibble_isa_pkg::LOAD_0: begin
            ctrl.ale = 1'b1;
         end
         nibble_isa_pkg::LOAD_1: begin
            ctrl.sel     = nibble_path_pkg::SEL_C1;
            ctrl.reg_tgt = 3'b000;
            ctrl.reg_we  = 1'b1;
            ctrl.ale     = 1'b1;
         end
         nibble_isa_pkg::LOAD_2: begin
            ctrl.sel     = nibble_path_pkg::SEL_C2;
            ctrl.reg_tgt = 3'b001;
            ctrl.reg_we  = 1'b1;
            ctrl.ale     = 1'b1;
         end
         nibble_isa_pkg::LOAD_3: begin
            ctrl.sel     = nibble_path_pkg::SEL_C3;
            ctrl.reg_tgt = 3'b010;
            ctrl.reg_we  = 1'b1;
            ctrl.ale     = 1'b1;
         end
         nibble_isa_pkg::LOAD_4: begin
            ctrl.sel     = nibble_path_pkg::SEL_PC_HALF;
            ctrl.reg_tgt = 3'b011;
            ctrl.reg_we  = 1'b1;
            ctrl.ale     = 1'b1;
         end
         nibble_isa_pkg::FETCH: begin
            ctrl.sel = nibble_path_pkg::SEL_PC_HALF;
            ctrl.ale = 1'b1;
         end
         nibble_isa_pkg::DECODE: begin
            ctrl.sel   = nibble_path_pkg::SEL_PC_INC;
            ctrl.ir_we = 1'b1;
            ctrl.pc_we = 1'b1;
         end
         nibble_isa_pkg::EXEC_1: begin
            case (ir)
               nibble_isa_pkg::IR_ADD: begin
                  ctrl.sel    = nibble_path_pkg::SEL_ADD;
                  ctrl.reg_we = 1'b1;
               end
               nibble_isa_pkg::IR_SUB: begin
                  ctrl.sel    = nibble_path_pkg::SEL_SUB;
                  ctrl.reg_we = 1'b1;
               end
               nibble_isa_pkg::IR_MUL: begin
                  ctrl.sel    = nibble_path_pkg::SEL_MUL;
                  ctrl.reg_we = 1'b1;
               end
               nibble_isa_pkg::IR_NAND: begin
                  ctrl.sel    = nibble_path_pkg::SEL_NAND;
                  ctrl.reg_we = 1'b1;
               end
               nibble_isa_pkg::IR_SW01: begin
                  ctrl.sel    = nibble_path_pkg::SEL_XOR01;
                  ctrl.reg_we = 1'b1;
               end
               nibble_isa_pkg::IR_SW12: begin
                  ctrl.sel     = nibble_path_pkg::SEL_XOR12;
                  ctrl.reg_tgt = 3'b101;
                  ctrl.reg_we  = 1'b1;
               end
               nibble_isa_pkg::IR_SW23: begin
                  ctrl.sel     = nibble_path_pkg::SEL_XOR23;
                  ctrl.reg_tgt = 3'b110;
                  ctrl.reg_we  = 1'b1;
               end
               nibble_isa_pkg::IR_BE: begin
                  ctrl.sel   = nibble_path_pkg::SEL_R3;
                  ctrl.pc_we = equal;
               end
               nibble_isa_pkg::IR_LDW, nibble_isa_pkg::IR_STW: begin
                  ctrl.sel = nibble_path_pkg::SEL_R3;
                  ctrl.ale = 1'b1;
               end
               nibble_isa_pkg::IR_REF: begin
                  ctrl.ale = 1'b1;
               end
               default: ;
            endcase
         end
         nibble_isa_pkg::EXEC_2: begin
            case (ir)
               nibble_isa_pkg::IR_SW01: begin
                  ctrl.sel     = nibble_path_pkg::SEL_XOR01;
                  ctrl.reg_tgt = 3'b101;
                  ctrl.reg_we  = 1'b1;
               end
               nibble_isa_pkg::IR_SW12: begin
                  ctrl.sel     = nibble_path_pkg::SEL_XOR12;
                  ctrl.reg_tgt = 3'b110;
                  ctrl.reg_we  = 1'b1;
               end
               nibble_isa_pkg::IR_SW23: begin
                  ctrl.sel     = nibble_path_pkg::SEL_XOR23;
                  ctrl.reg_tgt = 3'b111;
                  ctrl.reg_we  = 1'b1;
               end
               nibble_isa_pkg::IR_LDW: begin
                  ctrl.sel     = nibble_path_pkg::SEL_RDATA;
                  ctrl.reg_tgt = 3'b110;
                  ctrl.reg_we  = 1'b1;
               end
               nibble_isa_pkg::IR_STW: begin
                  ctrl.sel    = nibble_path_pkg::SEL_R2;
                  ctrl.mem_we = 1'b1;
               end
               nibble_isa_pkg::IR_REF: begin
                  // Byte 0 straight from the bus into r0
                  ctrl.reg_tgt = 3'b000;
                  ctrl.reg_we  = 1'b1;
               end
               default: ;
            endcase
         end
         nibble_isa_pkg::EXEC_3: begin
            case (ir)
               nibble_isa_pkg::IR_SW01: begin
                  ctrl.sel    = nibble_path_pkg::SEL_XOR01;
                  ctrl.reg_we = 1'b1;
               end
               nibble_isa_pkg::IR_SW12: begin
                  ctrl.sel     = nibble_path_pkg::SEL_XOR12;
                  ctrl.reg_tgt = 3'b101;
                  ctrl.reg_we  = 1'b1;
               end
               nibble_isa_pkg::IR_SW23: begin
                  ctrl.sel     = nibble_path_pkg::SEL_XOR23;
                  ctrl.reg_tgt = 3'b110;
                  ctrl.reg_we  = 1'b1;
               end
               default: ;
            endcase
         end
         default: ;
      endcase
   end

endmodule

// File: src/nibble_path_pkg.sv
`include "nibble_cpu_defs.svh"

package nibble_path_pkg;

   typedef enum logic [3:0] {
      SEL_ADD, SEL_SUB, SEL_MUL, SEL_NAND,
      SEL_XOR01, SEL_XOR12, SEL_XOR23,
      SEL_C0, SEL_C1, SEL_C2, SEL_C3,
      SEL_PC_HALF, SEL_PC_INC, SEL_R3,
      SEL_R2, SEL_RDATA
   } result_sel_e;

   typedef struct packed {
      result_sel_e sel;
      logic        ir_we;
      logic        pc_we;
      logic        reg_we;
      // Top bit set writes the result, clear writes read data
      logic [2:0]  reg_tgt;
      logic        ale;
      logic        mem_we;
   } ctrl_t;

   typedef struct packed {
      logic [`NC_WORD_W-1:0] addr;
      logic [`NC_WORD_W-1:0] wdata;
      logic                  we;
   } mem_req_t;

endpackage

// File: src/nibble_isa_pkg.sv
`include "nibble_cpu_defs.svh"

package nibble_isa_pkg;

   typedef enum logic [`NC_INSN_W-1:0] {
      IR_ADD   = 4'b0000,
      IR_SUB   = 4'b0001,
      IR_MUL   = 4'b0010,
      IR_NAND  = 4'b0011,
      IR_SW01  = 4'b0100,
      IR_SW12  = 4'b0101,
      IR_SW23  = 4'b0110,
      IR_BE    = 4'b0111,
      // Stack codes, no-ops in this core
      IR_POPC  = 4'b1000,
      IR_PUSHC = 4'b1001,
      IR_POP   = 4'b1010,
      IR_PUSH  = 4'b1011,
      IR_LDW   = 4'b1100,
      IR_STW   = 4'b1101,
      IR_REF   = 4'b1110,
      IR_INT   = 4'b1111
   } opcode_e;

   typedef enum logic [3:0] {
      LOAD_0, LOAD_1, LOAD_2, LOAD_3, LOAD_4,
      FETCH,
      DECODE,
      EXEC_1, EXEC_2, EXEC_3
   } seq_state_e;

endpackage

// File: src/nibble_cpu_defs.svh
`ifndef NIBBLE_CPU_DEFS_SVH
`define NIBBLE_CPU_DEFS_SVH

// Data and address width
`define NC_WORD_W 8

// Instruction width, two per byte
`define NC_INSN_W 4

// First nibble address after start-up, byte 4
`define NC_RESET_PC 8

// General registers loaded at start-up
`define NC_NUM_REGS 4

`endif
